//--- files.f
+incdir+common
+incdir+dv
common/conv_out_pkg.sv
common/out_beat_if.sv
quantizer/acc_quantizer.sv
quantizer/row_fifo_bank.sv
logic/conv_out_handler.sv
logic/out_buf_writer.sv
logic/conv_out_top.sv
dv/conv_out_tb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module conv_out_tb -f files.f > build.log 2>&1 \
    && ./obj_dir/Vconv_out_tb > sim.log 2>&1 \
    || echo "build or simulation ended with an error status"
if grep -qx "Testbench passed" sim.log 2>/dev/null; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- dv/conv_out_model.svh
`ifndef CONV_OUT_MODEL_SVH
`define CONV_OUT_MODEL_SVH

// reference model, included inside the testbench module

// arithmetic shift with round half up, clamped to a signed pixel
function automatic logic [`PIX_W-1:0] quant_pixel(
    input logic [`ACC_W-1:0] lane,
    input int sh
);
    int v;
    int r;
    v = int'($signed(lane));
    if (sh == 0) begin
        r = v;
    end else begin
        r = (v + (1 << (sh - 1))) >>> sh;
    end
    if (r > 127) begin
        r = 127;
    end else if (r < -128) begin
        r = -128;
    end
    return r[`PIX_W-1:0];
endfunction

// 16 pixels from the low or high half of one accumulator row
function automatic beat_data_t quant_half(input acc_row_t row, input int sh, input int half);
    beat_data_t q;
    for (int i = 0; i < `PE_COLS; i++) begin
        q[i*`PIX_W +: `PIX_W] = quant_pixel(row[(half*`PE_COLS+i)*`ACC_W +: `ACC_W], sh);
    end
    return q;
endfunction

function automatic buf_addr_t word_addr(
    input int y,
    input int f,
    input int x,
    input int of2p,
    input int ox2p
);
    int a;
    a = (((y << of2p) + f) << (ox2p - 4)) + (x >> 4);
    return buf_addr_t'(a);
endfunction

//////////////////////////////
// drain order
//////////////////////////////

// walks row, feature group and channel, queues pushes and expected writes
task automatic model_tile(
    input logic md,
    input int sh,
    input int poy,
    input int pof,
    input int oy0,
    input int ox0,
    input int of0,
    input int of2p,
    input int ox2p
);
    int cn;
    int step;
    int nch;
    acc_row_t row;
    cn = md ? 32 : 16;
    step = 0;
    row = '0;
    for (int oy = 0; oy < poy; oy++) begin
        for (int g = 0; g * cn < pof; g++) begin
            nch = (pof - g * cn < cn) ? pof - g * cn : cn;
            for (int c = 0; c < nch; c++) begin
                // mode 1 fetches a new entry every other channel
                if (!md || (c % 2 == 0)) begin
                    row = random_acc_row(sh);
                    push_row_q.push_back(row);
                    push_sel_q.push_back(fifo_sel_t'(oy * `SA_ROWS + g));
                    push_step_q.push_back(step);
                end
                exp_data_q.push_back(quant_half(row, sh, (md && (c % 2 == 1)) ? 1 : 0));
                exp_addr_q.push_back(word_addr(oy0 + oy, of0 + g * cn + c, ox0, of2p, ox2p));
                step++;
            end
        end
    end
endtask

`endif

//--- dv/conv_out_tb.sv
`timescale 1ns/100ps

`include "conv_out_params.svh"

module conv_out_tb import conv_out_pkg::*; ();

    // quantify_add_end rises this many cycles after the first push
    localparam int END_CYC = 4;
    localparam int TILE_TIMEOUT = 2000;

    logic clk;
    logic reset;
    logic mode;
    pow_t quant_shift;
    logic acc_valid;
    fifo_sel_t acc_sel;
    acc_row_t acc_data;
    logic quantify_add_end;
    idx_t cur_ox_start;
    idx_t cur_oy_start;
    idx_t cur_of_start;
    idx_t cur_poy;
    idx_t cur_pof;
    pow_t of_in_2pow;
    pow_t ox_in_2pow;
    logic buf_wr_en;
    buf_addr_t buf_wr_addr;
    beat_data_t buf_wr_data;
    logic conv_out_done;

    // rows to push in drain order, with the drain step that reads each
    acc_row_t push_row_q[$];
    fifo_sel_t push_sel_q[$];
    int push_step_q[$];
    buf_addr_t exp_addr_q[$];
    beat_data_t exp_data_q[$];

    int write_count;
    int done_count;
    string test_name;

    conv_out_top i_conv_out_top (
        .clk(clk),
        .reset(reset),
        .mode(mode),
        .quant_shift(quant_shift),
        .acc_valid(acc_valid),
        .acc_sel(acc_sel),
        .acc_data(acc_data),
        .quantify_add_end(quantify_add_end),
        .cur_ox_start(cur_ox_start),
        .cur_oy_start(cur_oy_start),
        .cur_of_start(cur_of_start),
        .cur_poy(cur_poy),
        .cur_pof(cur_pof),
        .of_in_2pow(of_in_2pow),
        .ox_in_2pow(ox_in_2pow),
        .buf_wr_en(buf_wr_en),
        .buf_wr_addr(buf_wr_addr),
        .buf_wr_data(buf_wr_data),
        .conv_out_done(conv_out_done)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string what, input logic [255:0] expected,
                               input logic [255:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("** Error: %s %s expected %0h actual %0h",
                               test_name, what, expected, actual));
        end
    endtask

    // lanes mix full range, both saturation edges and small values
    function automatic acc_row_t random_acc_row(input int sh);
        acc_row_t row;
        int v;
        for (int i = 0; i < `ACC_LANES; i++) begin
            case ($urandom % 4)
                0: v = int'($urandom);
                1: v = (127 << sh) + int'($urandom % (2 << sh)) - (1 << sh);
                2: v = -(128 << sh) + int'($urandom % (2 << sh)) - (1 << sh);
                default: v = int'($urandom % 64) - 32;
            endcase
            row[i*`ACC_W +: `ACC_W] = v[`ACC_W-1:0];
        end
        return row;
    endfunction

    `include "conv_out_model.svh"

    //////////////////////////////
    // one tile
    //////////////////////////////

    task automatic run_tile(input logic md, input int pof, input int poy, input int sh,
                            input bit abort);
        int of2p;
        int ox2p;
        int oy0;
        int ox0;
        int of0;
        int cyc;
        int idx;
        int t;
        int expected_writes;
        int writes_before;
        int dones_before;
        of2p = 5 + int'($urandom % 3);
        ox2p = 4 + int'($urandom % 4);
        oy0 = int'($urandom % 32);
        ox0 = int'($urandom % 256);
        of0 = int'($urandom % 64);
        @(posedge clk);
        mode <= md;
        quant_shift <= pow_t'(sh);
        cur_ox_start <= idx_t'(ox0);
        cur_oy_start <= idx_t'(oy0);
        cur_of_start <= idx_t'(of0);
        cur_poy <= idx_t'(poy);
        cur_pof <= idx_t'(pof);
        of_in_2pow <= pow_t'(of2p);
        ox_in_2pow <= pow_t'(ox2p);
        model_tile(md, sh, poy, pof, oy0, ox0, of0, of2p, ox2p);
        expected_writes = exp_addr_q.size();
        writes_before = write_count;
        dones_before = done_count;
        // each row lands a few cycles before the drain step that reads it
        cyc = 0;
        idx = 0;
        while (idx < push_step_q.size() || cyc <= END_CYC) begin
            @(posedge clk);
            quantify_add_end <= (cyc == END_CYC);
            acc_valid <= 1'b0;
            if (idx < push_step_q.size() && push_step_q[idx] == cyc) begin
                acc_valid <= 1'b1;
                acc_sel <= push_sel_q[idx];
                acc_data <= push_row_q[idx];
                idx++;
            end
            cyc++;
        end
        @(posedge clk);
        acc_valid <= 1'b0;
        quantify_add_end <= 1'b0;
        push_row_q.delete();
        push_sel_q.delete();
        push_step_q.delete();
        if (abort) begin
            // drain still has beats in flight here
            reset <= 1'b1;
            for (int i = 0; i < 4; i++) begin
                @(negedge clk);
                if (i > 0) begin
                    check_equal("buf_wr_en in reset", 0, buf_wr_en);
                    check_equal("conv_out_done in reset", 0, conv_out_done);
                end
            end
            @(posedge clk);
            exp_addr_q.delete();
            exp_data_q.delete();
            reset <= 1'b0;
            repeat (4) @(posedge clk);
        end else begin
            t = 0;
            while (done_count == dones_before) begin
                @(posedge clk);
                t++;
                if (t > TILE_TIMEOUT) begin
                    fail_run($sformatf("%s: tile did not finish within %0d cycles",
                                       test_name, TILE_TIMEOUT));
                end
            end
            // done belongs on the model's final write
            check_equal("writes at done", expected_writes, write_count - writes_before);
            repeat (3) @(posedge clk);
        end
    endtask

    // scoreboard for output buffer writes
    always @(negedge clk) begin
        if (!buf_wr_en) begin
            check_equal("conv_out_done without write", 0, conv_out_done);
        end else if (exp_addr_q.size() == 0) begin
            fail_run($sformatf("%s: output buffer write with none expected", test_name));
        end else begin
            check_equal("buf_wr_addr", exp_addr_q.pop_front(), buf_wr_addr);
            check_equal("buf_wr_data", exp_data_q.pop_front(), buf_wr_data);
            write_count++;
            if (conv_out_done) begin
                done_count++;
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin
        logic md;
        void'($urandom(32'h21c9d291));
        write_count = 0;
        done_count = 0;
        test_name = "reset";
        reset = 1'b1;
        mode = 1'b0;
        quant_shift = '0;
        acc_valid = 1'b0;
        acc_sel = '0;
        acc_data = '0;
        quantify_add_end = 1'b0;
        cur_ox_start = '0;
        cur_oy_start = '0;
        cur_of_start = '0;
        cur_poy = idx_t'(1);
        cur_pof = idx_t'(1);
        of_in_2pow = pow_t'(5);
        ox_in_2pow = pow_t'(4);
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        test_name = "quantization";
        for (int sh = 0; sh <= 8; sh++) begin
            run_tile(1'b0, 16, 1, sh, 1'b0);
        end

        test_name = "mode0_drain";
        run_tile(1'b0, 64, 3, int'($urandom % 9), 1'b0);
        for (int i = 0; i < 4; i++) begin
            run_tile(1'b0, 1 + int'($urandom % 64), 1 + int'($urandom % 3),
                     int'($urandom % 9), 1'b0);
        end

        test_name = "mode1_drain";
        run_tile(1'b1, 128, 3, int'($urandom % 9), 1'b0);
        for (int i = 0; i < 4; i++) begin
            run_tile(1'b1, 1 + int'($urandom % 128), 1 + int'($urandom % 3),
                     int'($urandom % 9), 1'b0);
        end

        test_name = "back_to_back";
        for (int i = 0; i < 8; i++) begin
            md = 1'($urandom % 2);
            run_tile(md, 1 + int'($urandom % (md ? 128 : 64)), 1 + int'($urandom % 3),
                     int'($urandom % 9), 1'b0);
        end

        test_name = "reset_mid_drain";
        run_tile(1'b0, 64, 3, int'($urandom % 9), 1'b1);
        run_tile(1'b1, 1 + int'($urandom % 128), 2, int'($urandom % 9), 1'b0);

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- logic/conv_out_top.sv
`timescale 1ns/100ps

module conv_out_top import conv_out_pkg::*; (
    input logic clk,
    input logic reset,
    input logic mode,
    input pow_t quant_shift,
    input logic acc_valid,
    input fifo_sel_t acc_sel,
    input acc_row_t acc_data,
    input logic quantify_add_end,
    input idx_t cur_ox_start,
    input idx_t cur_oy_start,
    input idx_t cur_of_start,
    input idx_t cur_poy,
    input idx_t cur_pof,
    input pow_t of_in_2pow,
    input pow_t ox_in_2pow,
    output logic buf_wr_en,
    output buf_addr_t buf_wr_addr,
    output beat_data_t buf_wr_data,
    output logic conv_out_done
);

    logic q_valid;
    fifo_sel_t q_sel;
    q_row_t q_data;
    fifo_mask_t fifo_rds;
    q_row_t rd_data;

    out_beat_if beat_if ();

    //////////////////////////////
    // quantize and buffer rows
    //////////////////////////////

    acc_quantizer i_acc_quantizer (
        .clk(clk),
        .reset(reset),
        .quant_shift(quant_shift),
        .acc_valid(acc_valid),
        .acc_sel(acc_sel),
        .acc_data(acc_data),
        .q_valid(q_valid),
        .q_sel(q_sel),
        .q_data(q_data)
    );

    row_fifo_bank i_row_fifo_bank (
        .clk(clk),
        .reset(reset),
        .q_valid(q_valid),
        .q_sel(q_sel),
        .q_data(q_data),
        .fifo_rds(fifo_rds),
        .rd_data(rd_data)
    );

    //////////////////////////////
    // drain to output buffer
    //////////////////////////////

    conv_out_handler i_conv_out_handler (
        .clk(clk),
        .reset(reset),
        .mode(mode),
        .quantify_add_end(quantify_add_end),
        .cur_ox_start(cur_ox_start),
        .cur_oy_start(cur_oy_start),
        .cur_of_start(cur_of_start),
        .cur_poy(cur_poy),
        .cur_pof(cur_pof),
        .fifo_rds(fifo_rds),
        .rd_data(rd_data),
        .beat(beat_if.src)
    );

    out_buf_writer i_out_buf_writer (
        .clk(clk),
        .reset(reset),
        .of_in_2pow(of_in_2pow),
        .ox_in_2pow(ox_in_2pow),
        .beat(beat_if.dst),
        .buf_wr_en(buf_wr_en),
        .buf_wr_addr(buf_wr_addr),
        .buf_wr_data(buf_wr_data),
        .conv_out_done(conv_out_done)
    );

endmodule

//--- logic/out_buf_writer.sv
`timescale 1ns/100ps

`include "conv_out_params.svh"

module out_buf_writer import conv_out_pkg::*; (
    input logic clk,
    input logic reset,
    input pow_t of_in_2pow,
    input pow_t ox_in_2pow,
    out_beat_if.dst beat,
    output logic buf_wr_en,
    output buf_addr_t buf_wr_addr,
    output beat_data_t buf_wr_data,
    output logic conv_out_done
);

    // pixels per buffer word, log2
    localparam int PIX_SHIFT = $clog2(`PE_COLS);

    buf_addr_t row_base;
    buf_addr_t word_addr;

    // one line of features per output row, words of 16 pixels along x
    assign row_base = buf_addr_t'((beat.y_idx << of_in_2pow) + beat.f_idx);
    assign word_addr = buf_addr_t'(row_base << (ox_in_2pow - pow_t'(PIX_SHIFT)))
                       + buf_addr_t'(beat.x_idx >> PIX_SHIFT);

    //////////////////////////////
    // write port
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_wr_en <= 1'b0;
            conv_out_done <= 1'b0;
        end else begin
            buf_wr_en <= beat.valid;
            // single pulse on the tile's final write
            conv_out_done <= beat.valid && beat.last;
        end
    end

    always_ff @(posedge clk) begin
        buf_wr_addr <= word_addr;
        buf_wr_data <= beat.data;
    end

endmodule

//--- logic/conv_out_handler.sv
`timescale 1ns/100ps

`include "conv_out_params.svh"

module conv_out_handler import conv_out_pkg::*; (
    input logic clk,
    input logic reset,
    input logic mode,
    input logic quantify_add_end,
    input idx_t cur_ox_start,
    input idx_t cur_oy_start,
    input idx_t cur_of_start,
    input idx_t cur_poy,
    input idx_t cur_pof,
    output fifo_mask_t fifo_rds,
    input q_row_t rd_data,
    out_beat_if.src beat
);

    localparam int BEAT_W = $bits(beat_data_t);

    drain_state_t state;

    idx_t channel_counter;
    idx_t of_counter;
    idx_t oy_counter;
    idx_t channel_num;
    pow_t log_channel_num;
    // of_counter - 1 + channel_counter
    idx_t f_offset;
    idx_t fifo_idx;

    logic step;
    logic pof_hit;
    logic ch_end;
    logic of_end;
    logic oy_end;
    logic rd_en;
    logic half_hi;

    // mode 1 packs two channels per entry
    assign channel_num = mode ? idx_t'(32) : idx_t'(16);
    assign log_channel_num = mode ? pow_t'(5) : pow_t'(4);

    assign step = (state == drain);
    assign f_offset = of_counter + channel_counter - idx_t'(1);
    assign pof_hit = (f_offset == cur_pof);

    // loop ends, innermost first
    assign ch_end = step && (pof_hit || (channel_counter == channel_num));
    assign of_end = ch_end && pof_hit;
    assign oy_end = of_end && (oy_counter == cur_poy);

    //////////////////////////////
    // drain fsm
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (quantify_add_end) begin
                        state <= drain;
                    end
                end
                drain: begin
                    if (oy_end) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // nested loop counters, all rest at 1
    always_ff @(posedge clk) begin
        if (reset) begin
            channel_counter <= idx_t'(1);
            of_counter <= idx_t'(1);
            oy_counter <= idx_t'(1);
        end else if (step) begin
            channel_counter <= ch_end ? idx_t'(1) : channel_counter + idx_t'(1);
            if (of_end) begin
                of_counter <= idx_t'(1);
            end else if (ch_end) begin
                of_counter <= of_counter + channel_num;
            end
            if (oy_end) begin
                oy_counter <= idx_t'(1);
            end else if (of_end) begin
                oy_counter <= oy_counter + idx_t'(1);
            end
        end
    end

    //////////////////////////////
    // fifo read strobes
    //////////////////////////////

    // one fifo per output row and feature group
    assign fifo_idx = (oy_counter - idx_t'(1)) * idx_t'(`SA_ROWS)
                      + ((of_counter - idx_t'(1)) >> log_channel_num);

    // mode 1 reads on odd channels only
    assign rd_en = step && (!mode || channel_counter[0]);

    always_comb begin
        for (int i = 0; i < `NUM_FIFOS; i++) begin
            fifo_rds[i] = rd_en && (fifo_idx == idx_t'(i));
        end
    end

    // beat follows its step by one cycle, with the fifo data
    always_ff @(posedge clk) begin
        if (reset) begin
            beat.valid <= 1'b0;
            beat.last <= 1'b0;
        end else begin
            beat.valid <= step;
            beat.last <= oy_end;
        end
    end

    always_ff @(posedge clk) begin
        beat.y_idx <= cur_oy_start + oy_counter - idx_t'(1);
        beat.x_idx <= cur_ox_start;
        beat.f_idx <= cur_of_start + f_offset - idx_t'(1);
        // even channel in mode 1 takes the upper channel of the entry
        half_hi <= mode && !channel_counter[0];
    end

    assign beat.data = !beat.valid ? '0
                     : half_hi ? rd_data[2*BEAT_W-1:BEAT_W]
                     : rd_data[BEAT_W-1:0];

endmodule

//--- quantizer/row_fifo_bank.sv
`timescale 1ns/100ps

`include "conv_out_params.svh"

module row_fifo_bank import conv_out_pkg::*; (
    input logic clk,
    input logic reset,
    input logic q_valid,
    input fifo_sel_t q_sel,
    input q_row_t q_data,
    input fifo_mask_t fifo_rds,
    output q_row_t rd_data
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    q_row_t mem [`NUM_FIFOS][`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr [`NUM_FIFOS];
    logic [PTR_W-1:0] rd_ptr [`NUM_FIFOS];
    logic [PTR_W:0] count [`NUM_FIFOS];
    fifo_mask_t push;
    fifo_mask_t pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // full fifo drops the write, empty fifo ignores the strobe
    always_comb begin
        for (int i = 0; i < `NUM_FIFOS; i++) begin
            push[i] = q_valid && (q_sel == fifo_sel_t'(i))
                      && (count[i] != (PTR_W + 1)'(`FIFO_DEPTH));
            pop[i] = fifo_rds[i] && (count[i] != '0);
        end
    end

    //////////////////////////////
    // pointers and fill counts
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_FIFOS; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_FIFOS; i++) begin
                if (push[i]) begin
                    wr_ptr[i] <= next_ptr(wr_ptr[i]);
                end
                if (pop[i]) begin
                    rd_ptr[i] <= next_ptr(rd_ptr[i]);
                end
                if (push[i] && !pop[i]) begin
                    count[i] <= count[i] + 1'b1;
                end else if (pop[i] && !push[i]) begin
                    count[i] <= count[i] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_FIFOS; i++) begin
            if (push[i]) begin
                mem[i][wr_ptr[i]] <= q_data;
            end
        end
    end

    // read mux, holds the last entry while no fifo is strobed
    // mode 1 takes the high half from the held entry
    always_ff @(posedge clk) begin
        if (|fifo_rds) begin
            rd_data <= '0;
            for (int i = 0; i < `NUM_FIFOS; i++) begin
                if (pop[i]) begin
                    rd_data <= mem[i][rd_ptr[i]];
                end
            end
        end
    end

endmodule

//--- quantizer/acc_quantizer.sv
`timescale 1ns/100ps

`include "conv_out_params.svh"

module acc_quantizer import conv_out_pkg::*; (
    input logic clk,
    input logic reset,
    input pow_t quant_shift,
    input logic acc_valid,
    input fifo_sel_t acc_sel,
    input acc_row_t acc_data,
    output logic q_valid,
    output fifo_sel_t q_sel,
    output q_row_t q_data
);

    // one guard bit so the rounding add cannot wrap
    localparam int EXT_W = `ACC_W + 1;

    typedef logic signed [EXT_W-1:0] ext_t;

    localparam ext_t PIX_MAX = ext_t'(2 ** (`PIX_W - 1) - 1);
    localparam ext_t PIX_MIN = -ext_t'(2 ** (`PIX_W - 1));

    q_row_t q_next;

    // arithmetic shift right, round half up, clamp to signed pixel
    function automatic logic [`PIX_W-1:0] quantize_lane(
        input logic [`ACC_W-1:0] lane,
        input pow_t sh
    );
        ext_t ext;
        ext_t rnd;
        ext_t scaled;
        ext = {lane[`ACC_W-1], lane};
        rnd = (sh == '0) ? '0 : (ext_t'(1) <<< (sh - pow_t'(1)));
        scaled = (ext + rnd) >>> sh;
        if (scaled > PIX_MAX) begin
            return PIX_MAX[`PIX_W-1:0];
        end
        if (scaled < PIX_MIN) begin
            return PIX_MIN[`PIX_W-1:0];
        end
        return scaled[`PIX_W-1:0];
    endfunction

    always_comb begin
        for (int i = 0; i < `ACC_LANES; i++) begin
            q_next[i*`PIX_W +: `PIX_W] = quantize_lane(acc_data[i*`ACC_W +: `ACC_W],
                                                       quant_shift);
        end
    end

    //////////////////////////////
    // output register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= acc_valid;
        end
    end

    // row and its fifo index travel together
    always_ff @(posedge clk) begin
        q_sel <= acc_sel;
        q_data <= q_next;
    end

endmodule

//--- common/out_beat_if.sv
`timescale 1ns/100ps

// one output beat, handler to buffer writer, no handshake
interface out_beat_if import conv_out_pkg::*; ();

    logic valid;
    idx_t y_idx;
    idx_t x_idx;
    idx_t f_idx;
    beat_data_t data;
    // final beat of the tile
    logic last;

    modport src (
        output valid, y_idx, x_idx, f_idx, data, last
    );

    modport dst (
        input valid, y_idx, x_idx, f_idx, data, last
    );

endinterface

//--- common/conv_out_pkg.sv
`include "conv_out_params.svh"

package conv_out_pkg;

    // tile coordinates, counts and log2 sizes
    typedef logic [15:0] idx_t;
    typedef logic [3:0] pow_t;

    // one row out of the accumulators, 32 signed lanes
    typedef logic [`ACC_LANES*`ACC_W-1:0] acc_row_t;

    // one row fifo entry after quantization
    typedef logic [`ACC_LANES*`PIX_W-1:0] q_row_t;

    // 16 pixels of a single channel
    typedef logic [`PE_COLS*`PIX_W-1:0] beat_data_t;

    typedef logic [$clog2(`NUM_FIFOS)-1:0] fifo_sel_t;
    typedef logic [`NUM_FIFOS-1:0] fifo_mask_t;

    typedef logic [`BUF_ADDR_W-1:0] buf_addr_t;

    // output handler drain fsm
    typedef enum logic {
        idle,
        drain
    } drain_state_t;

endpackage

//--- common/conv_out_params.svh
`ifndef CONV_OUT_PARAMS_SVH
`define CONV_OUT_PARAMS_SVH

// systolic array geometry
`define SA_ROWS 4
`define SA_COLS 3
`define NUM_FIFOS (`SA_ROWS * `SA_COLS)
`define PE_COLS 16

// datapath widths
`define PIX_W 8
`define ACC_W 16
`define ACC_LANES 32

// row fifo and output buffer
`define FIFO_DEPTH 8
`define BUF_ADDR_W 16

`endif
